// ==== Makefile ====
# Verilator build and run for the PRBS link self-test

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_prbs_link_test
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard verilog/*.svh verification/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx 'test passed' $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
+incdir+verilog
+incdir+verification
verilog/prbs_test_pkg.sv
verilog/slow_tick_gen.sv
verilog/link_boot_sequencer.sv
verilog/front_panel_led.sv
verilog/prbs_link_test_top.sv
verification/tb_prbs_link_test.sv

// ==== verification/prbs_ref_model.svh ====
`ifndef PRBS_REF_MODEL_SVH
`define PRBS_REF_MODEL_SVH

// Predicted DUT state advanced on every rising clk40 edge
int          m_run_cycles = 0;
logic        m_tick       = 1'b0;
logic        m_blink      = 1'b0;
boot_state_t m_state      = BOOT_RESET;
int          m_cnt        = 0;
disp_vec_t   m_latch      = '0;

// Error counters run only once the receivers are up
function automatic logic counters_held(input boot_state_t st);
    return !(st inside {BOOT_RX_DONE, BOOT_INJECT, BOOT_CHECK});
endfunction

function automatic boot_state_t predict_next_state(input lane_vec_t tx_done,
                                                   input lane_vec_t rx_done);
    case (m_state)
        BOOT_RESET:        return BOOT_EN_TX;
        BOOT_EN_TX:        return (m_cnt >= `PRBS_RESET_WAIT) ? BOOT_TX_DONE : BOOT_EN_TX;
        BOOT_TX_DONE:      return (&tx_done) ? BOOT_EN_RX : BOOT_TX_DONE;
        BOOT_EN_RX:        return (m_cnt >= `PRBS_RESET_WAIT) ? BOOT_RX_DONE : BOOT_EN_RX;
        BOOT_RX_DONE:      return (&rx_done) ? BOOT_INJECT : BOOT_RX_DONE;
        BOOT_INJECT:       return (m_cnt == `PRBS_INJECT_TICKS) ? BOOT_INJECT_CLEAR : BOOT_INJECT;
        BOOT_INJECT_CLEAR: return BOOT_CHECK;
        default:           return m_state;
    endcase
endfunction

// Expected {tx reset, rx reset, count reset, inject, LED}
function automatic logic [31:0] expected_outputs(input logic button);
    lane_vec_t tx_rst;
    lane_vec_t rx_rst;
    logic      inj;
    led_code_t code;
    disp_vec_t low;
    tx_rst = (m_state == BOOT_RESET) ? '1 : '0;
    rx_rst = (m_state inside {BOOT_RESET, BOOT_EN_TX, BOOT_TX_DONE}) ? '1 : '0;
    // Button only counts once the check phase is reached
    inj = (m_state == BOOT_CHECK) ? button : (m_state inside {BOOT_RX_DONE, BOOT_INJECT});
    case (m_state)
        BOOT_EN_TX:        code = `PRBS_LED_TX;
        BOOT_TX_DONE:      code = `PRBS_LED_TX_DONE;
        BOOT_EN_RX:        code = `PRBS_LED_RX;
        BOOT_RX_DONE:      code = `PRBS_LED_RX_DONE;
        BOOT_INJECT:       code = `PRBS_LED_INJECT;
        BOOT_INJECT_CLEAR: code = `PRBS_LED_CLEAR;
        BOOT_CHECK:        code = `PRBS_LED_CHECK;
        default:           code = `PRBS_LED_RESET;
    endcase
    low = '0;
    if (m_state inside {BOOT_INJECT, BOOT_INJECT_CLEAR, BOOT_CHECK}) begin
        low = m_latch | {`PRBS_DISP_LANES{m_blink}};
    end
    return {6'd0, tx_rst, rx_rst, counters_held(m_state), inj, code, low};
endfunction

// Expected {tick, blink, state, counter}
function automatic logic [31:0] expected_internals();
    return 32'({m_tick, m_blink, m_state, tick_cnt_t'(m_cnt)});
endfunction

task automatic advance_model(input logic      rst,
                             input lane_vec_t tx_done,
                             input lane_vec_t rx_done,
                             input disp_vec_t err);
    boot_state_t nxt;
    logic        cnt_clear;
    nxt       = predict_next_state(tx_done, rx_done);
    cnt_clear = m_state inside {BOOT_RESET, BOOT_TX_DONE, BOOT_RX_DONE};
    // Latch sees the count reset of the state before this edge
    if (counters_held(m_state)) begin
        m_latch = '0;
    end else begin
        m_latch = m_latch | err;
    end
    if (rst) begin
        m_run_cycles = 0;
        m_tick       = 1'b0;
        m_blink      = 1'b0;
        m_state      = BOOT_RESET;
        m_cnt        = 0;
    end else begin
        // State and counter move on a tick and blink flips right after it
        if (m_tick) begin
            m_state = nxt;
            m_cnt   = cnt_clear ? 0 : (m_cnt + 1) % (1 << `PRBS_CNT_W);
            m_blink = !m_blink;
        end
        m_run_cycles++;
        // One tick per divider period counted from reset release
        m_tick = (m_run_cycles % `PRBS_SLOW_DIV) == 0;
    end
endtask

`endif

// ==== verification/tb_prbs_link_test.sv ====
`timescale 1ns/1ps
`include "prbs_test_macros.svh"

module tb_prbs_link_test import prbs_test_pkg::*; ();

    logic                   clk40 = 1'b0;
    logic                   PRBS_reset;
    lane_vec_t              tx_reset_done_i;
    lane_vec_t              rx_reset_done_i;
    disp_vec_t              disp_prbs_error_i;
    logic                   inject_i;
    lane_vec_t              full_tx_reset_o;
    lane_vec_t              full_rx_reset_o;
    logic                   prbs_count_reset_o;
    logic                   prbs_error_inject_o;
    logic [`PRBS_LED_W-1:0] led_fp_o;

    // Per lane done delays in cycles after reset release
    int   tx_delay [`PRBS_NUM_LANES];
    int   rx_delay [`PRBS_NUM_LANES];
    int   tx_age      = 0;
    int   rx_age      = 0;
    logic err_en      = 1'b0;
    logic inject_rand = 1'b0;
    // Run bookkeeping
    int   checks      = 0;
    int   errors      = 0;
    int   test_checks = 0;
    int   test_errors = 0;
    logic timed_out   = 1'b0;

    `include "prbs_ref_model.svh"

    prbs_link_test_top prbs_link_test_top_i (
        .clk40               (clk40),
        .PRBS_reset          (PRBS_reset),
        .tx_reset_done_i     (tx_reset_done_i),
        .rx_reset_done_i     (rx_reset_done_i),
        .disp_prbs_error_i   (disp_prbs_error_i),
        .inject_i            (inject_i),
        .full_tx_reset_o     (full_tx_reset_o),
        .full_rx_reset_o     (full_rx_reset_o),
        .prbs_count_reset_o  (prbs_count_reset_o),
        .prbs_error_inject_o (prbs_error_inject_o),
        .led_fp_o            (led_fp_o)
    );

    initial begin
        forever #10 clk40 = ~clk40;
    end

    //////////////////////////////
    // Model and cycle checker
    //////////////////////////////

    always @(posedge clk40) begin
        advance_model(PRBS_reset, tx_reset_done_i, rx_reset_done_i, disp_prbs_error_i);
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error [%0t] %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk40) begin
        check_value("outputs vs model", 32'({full_tx_reset_o, full_rx_reset_o,
            prbs_count_reset_o, prbs_error_inject_o, led_fp_o}), expected_outputs(inject_i));
        check_value("tick, blink, state, counter vs model",
            32'({prbs_link_test_top_i.slow_tick, prbs_link_test_top_i.blink,
                 prbs_link_test_top_i.boot_state,
                 prbs_link_test_top_i.link_boot_sequencer_i.cnt_q}),
            expected_internals());
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic drive_inputs();
        disp_vec_t err;
        int        l;
        // Done flags rise at a random delay after each reset is released
        tx_age = (full_tx_reset_o == '0) ? tx_age + 1 : 0;
        rx_age = (full_rx_reset_o == '0) ? rx_age + 1 : 0;
        for (l = 0; l < `PRBS_NUM_LANES; l++) begin
            tx_reset_done_i[l] = (tx_age > tx_delay[l]);
            rx_reset_done_i[l] = (rx_age > rx_delay[l]);
        end
        // Single cycle error pulse on one displayed lane
        err = '0;
        if (err_en && $urandom_range(0, 5) == 0) begin
            err[$urandom_range(0, `PRBS_DISP_LANES - 1)] = 1'b1;
        end
        disp_prbs_error_i = err;
        if (inject_rand && $urandom_range(0, 3) == 0) begin
            inject_i = !inject_i;
        end
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk40);
        #2;
        drive_inputs();
    endtask

    task automatic note_timeout(input string what, input int limit);
        $display("Timeout: %s did not happen within %0d cycles", what, limit);
        timed_out = 1'b1;
    endtask

    task automatic wait_state(input boot_state_t target, input int limit, input string what);
        int n;
        n = 0;
        while (prbs_link_test_top_i.boot_state != target && n < limit) begin
            step();
            n++;
        end
        if (prbs_link_test_top_i.boot_state != target) begin
            note_timeout(what, limit);
        end
    endtask

    task automatic check_reset_outputs(input string what);
        @(negedge clk40);
        check_value(what, 32'({full_tx_reset_o, full_rx_reset_o, prbs_count_reset_o,
            prbs_error_inject_o, led_fp_o}), 32'({lane_vec_t'('1), lane_vec_t'('1),
            1'b1, 1'b0, `PRBS_LED_RESET, disp_vec_t'('0)}));
    endtask

    task automatic close_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    //////////////////////////////
    // Test sequences
    //////////////////////////////

    task automatic hold_in_reset();
        int i;
        // Eight edges under reset and release right after the last one
        for (i = 0; i < 8; i++) begin
            step();
            if (i < 7) begin
                check_reset_outputs("outputs under reset");
            end
        end
        PRBS_reset = 1'b0;
    endtask

    task automatic release_transmitters();
        int n;
        wait_state(BOOT_EN_TX, 2 * `PRBS_SLOW_DIV, "transmit release");
        if (timed_out) begin
            return;
        end
        @(negedge clk40);
        check_value("tx reset after first tick", 32'(full_tx_reset_o), 32'd0);
        check_value("rx reset while tx starts", 32'(full_rx_reset_o), 32'(lane_vec_t'('1)));
        n = 0;
        while (full_rx_reset_o != '0 && n < 400) begin
            step();
            @(negedge clk40);
            n++;
        end
        if (full_rx_reset_o != '0) begin
            note_timeout("receive release", 400);
            return;
        end
        check_value("all tx done at rx release", 32'(&tx_reset_done_i), 32'd1);
        check_value("tx wait passed at rx release",
                    32'(tx_age >= (`PRBS_RESET_WAIT + 1) * `PRBS_SLOW_DIV), 32'd1);
    endtask

    task automatic walk_inject_window();
        int n;
        wait_state(BOOT_INJECT, 400, "forced injection");
        if (timed_out) begin
            return;
        end
        // Errors start arriving with the forced window
        err_en = 1'b1;
        n = 0;
        while (prbs_link_test_top_i.boot_state == BOOT_INJECT && n < 40 * `PRBS_SLOW_DIV) begin
            @(negedge clk40);
            check_value("inject forced", 32'(prbs_error_inject_o), 32'd1);
            check_value("LED code in inject", 32'(led_fp_o[7:4]), 32'(`PRBS_LED_INJECT));
            step();
            n++;
        end
        if (prbs_link_test_top_i.boot_state == BOOT_INJECT) begin
            note_timeout("end of inject window", n);
            return;
        end
        check_value("inject window length", 32'(n),
                    32'((`PRBS_INJECT_TICKS + 1) * `PRBS_SLOW_DIV));
        n = 0;
        while (prbs_link_test_top_i.boot_state == BOOT_INJECT_CLEAR &&
               n < 2 * `PRBS_SLOW_DIV) begin
            @(negedge clk40);
            check_value("inject off in clear", 32'(prbs_error_inject_o), 32'd0);
            check_value("count reset in clear", 32'(prbs_count_reset_o), 32'd1);
            check_value("LED code in clear", 32'(led_fp_o[7:4]), 32'(`PRBS_LED_CLEAR));
            // Latch empty from the second clear cycle on
            if (n > 0) begin
                check_value("latch cleared", 32'(led_fp_o[3:0]),
                            32'({`PRBS_DISP_LANES{m_blink}}));
            end
            step();
            n++;
        end
        check_value("clear state length", 32'(n), 32'(`PRBS_SLOW_DIV));
        check_value("state after clear", 32'(prbs_link_test_top_i.boot_state),
                    32'(BOOT_CHECK));
    endtask

    task automatic latch_random_errors();
        disp_vec_t seen;
        int        i;
        // Lanes hit since the check phase began
        seen = '0;
        for (i = 0; i < 200; i++) begin
            @(negedge clk40);
            check_value("LED in check", 32'(led_fp_o),
                        32'({`PRBS_LED_CHECK, seen | {`PRBS_DISP_LANES{m_blink}}}));
            seen = seen | disp_prbs_error_i;
            step();
        end
        check_value("error pulses seen", 32'(seen != '0), 32'd1);
        err_en = 1'b0;
    endtask

    task automatic follow_button_then_reset();
        int i;
        inject_rand = 1'b1;
        for (i = 0; i < 150; i++) begin
            @(negedge clk40);
            check_value("inject follows button", 32'(prbs_error_inject_o), 32'(inject_i));
            step();
        end
        inject_rand = 1'b0;
        inject_i    = 1'b0;
        PRBS_reset  = 1'b1;
        for (i = 0; i < 8; i++) begin
            step();
            check_reset_outputs("outputs after mid-run reset");
        end
        step();
        PRBS_reset = 1'b0;
        // Sequence starts over after release
        wait_state(BOOT_EN_TX, 2 * `PRBS_SLOW_DIV, "restart after reset");
    endtask

    initial begin
        int l;
        void'($urandom(32'h3d82_13e2));
        PRBS_reset        = 1'b1;
        tx_reset_done_i   = '0;
        rx_reset_done_i   = '0;
        disp_prbs_error_i = '0;
        inject_i          = 1'b0;
        for (l = 0; l < `PRBS_NUM_LANES; l++) begin
            tx_delay[l] = $urandom_range(0, 100);
            rx_delay[l] = $urandom_range(0, 100);
        end

        hold_in_reset();
        close_test("[1] reset hold");
        if (!timed_out) begin
            release_transmitters();
            close_test("[2] staggered transmit release");
        end
        if (!timed_out) begin
            walk_inject_window();
            close_test("[3] receive release, inject window, clear");
        end
        if (!timed_out) begin
            latch_random_errors();
            close_test("[4] front panel error latch");
        end
        if (!timed_out) begin
            follow_button_then_reset();
            close_test("[5] inject button and mid-run reset");
        end

        $display("Total: %0d checks, %0d errors%s", checks, errors,
                 timed_out ? ", run stopped on a timeout" : "");
        if (errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/prbs_link_test_top.sv ====
`timescale 1ns/1ps
`include "prbs_test_macros.svh"

module prbs_link_test_top import prbs_test_pkg::*; (
    input  logic                   clk40,
    input  logic                   PRBS_reset,
    // Reset done flags from the transceivers
    input  lane_vec_t              tx_reset_done_i,
    input  lane_vec_t              rx_reset_done_i,
    // PRBS error flags of the displayed lanes
    input  disp_vec_t              disp_prbs_error_i,
    // Front panel inject button
    input  logic                   inject_i,
    // Transceiver controls
    output lane_vec_t              full_tx_reset_o,
    output lane_vec_t              full_rx_reset_o,
    output logic                   prbs_count_reset_o,
    output logic                   prbs_error_inject_o,
    output logic [`PRBS_LED_W-1:0] led_fp_o
);

    logic        slow_tick;
    logic        blink;
    boot_state_t boot_state;
    logic        prbs_count_reset;

    // Slow tick enable and blink phase
    slow_tick_gen slow_tick_gen_i (
        .clk40       (clk40),
        .PRBS_reset  (PRBS_reset),
        .slow_tick_o (slow_tick),
        .blink_o     (blink)
    );

    // Link bring-up sequence
    link_boot_sequencer link_boot_sequencer_i (
        .clk40               (clk40),
        .PRBS_reset          (PRBS_reset),
        .slow_tick_i         (slow_tick),
        .tx_reset_done_i     (tx_reset_done_i),
        .rx_reset_done_i     (rx_reset_done_i),
        .inject_i            (inject_i),
        .boot_state_o        (boot_state),
        .full_tx_reset_o     (full_tx_reset_o),
        .full_rx_reset_o     (full_rx_reset_o),
        .prbs_count_reset_o  (prbs_count_reset),
        .prbs_error_inject_o (prbs_error_inject_o)
    );

    assign prbs_count_reset_o = prbs_count_reset;

    // Error latch and LED drive
    front_panel_led front_panel_led_i (
        .clk40              (clk40),
        .prbs_count_reset_i (prbs_count_reset),
        .boot_state_i       (boot_state),
        .blink_i            (blink),
        .disp_prbs_error_i  (disp_prbs_error_i),
        .led_fp_o           (led_fp_o)
    );

endmodule

// ==== verilog/front_panel_led.sv ====
`timescale 1ns/1ps
`include "prbs_test_macros.svh"

module front_panel_led import prbs_test_pkg::*; (
    input  logic                  clk40,
    input  logic                  prbs_count_reset_i,
    input  boot_state_t           boot_state_i,
    input  logic                  blink_i,
    input  disp_vec_t             disp_prbs_error_i,
    output logic [`PRBS_LED_W-1:0] led_fp_o
);

    // Sticky error flags of the displayed lanes
    disp_vec_t latch_q;
    disp_vec_t err_nibble;
    led_code_t led_code;
    // Lower nibble active in the PRBS phases
    logic      show_err;

    //////////////////////////////
    // Error latch
    //////////////////////////////

    // Cleared along with the transceiver error counters
    always_ff @(posedge clk40) begin
        if (prbs_count_reset_i) begin
            latch_q <= '0;
        end else begin
            latch_q <= latch_q | disp_prbs_error_i;
        end
    end

    //////////////////////////////
    // LED encoder
    //////////////////////////////

    always_comb begin
        led_code = `PRBS_LED_RESET;
        show_err = 1'b0;
        case (boot_state_i)
            BOOT_RESET:   led_code = `PRBS_LED_RESET;
            BOOT_EN_TX:   led_code = `PRBS_LED_TX;
            BOOT_TX_DONE: led_code = `PRBS_LED_TX_DONE;
            BOOT_EN_RX:   led_code = `PRBS_LED_RX;
            BOOT_RX_DONE: led_code = `PRBS_LED_RX_DONE;
            BOOT_INJECT: begin
                led_code = `PRBS_LED_INJECT;
                show_err = 1'b1;
            end
            BOOT_INJECT_CLEAR: begin
                led_code = `PRBS_LED_CLEAR;
                show_err = 1'b1;
            end
            BOOT_CHECK: begin
                led_code = `PRBS_LED_CHECK;
                show_err = 1'b1;
            end
            default:      led_code = `PRBS_LED_RESET;
        endcase
    end

    // Latched lane errors stay lit, clean lanes blink
    assign err_nibble = show_err ? (latch_q | {`PRBS_DISP_LANES{blink_i}}) : '0;

    assign led_fp_o = {led_code, err_nibble};

endmodule

// ==== verilog/link_boot_sequencer.sv ====
`timescale 1ns/1ps
`include "prbs_test_macros.svh"

module link_boot_sequencer import prbs_test_pkg::*; (
    input  logic        clk40,
    input  logic        PRBS_reset,
    input  logic        slow_tick_i,
    input  lane_vec_t   tx_reset_done_i,
    input  lane_vec_t   rx_reset_done_i,
    input  logic        inject_i,
    output boot_state_t boot_state_o,
    output lane_vec_t   full_tx_reset_o,
    output lane_vec_t   full_rx_reset_o,
    output logic        prbs_count_reset_o,
    output logic        prbs_error_inject_o
);

    boot_state_t state_q;
    boot_state_t state_next;
    tick_cnt_t   cnt_q;
    // Counter restarts on the next tick
    logic        cnt_clear;
    logic        tx_all_done;
    logic        rx_all_done;

    assign tx_all_done = &tx_reset_done_i;
    assign rx_all_done = &rx_reset_done_i;

    //////////////////////////////
    // State and tick counter
    //////////////////////////////

    // Both move only on slow ticks
    always_ff @(posedge clk40) begin
        if (PRBS_reset) begin
            state_q <= BOOT_RESET;
            cnt_q   <= '0;
        end else if (slow_tick_i) begin
            state_q <= state_next;
            if (cnt_clear) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // Wait states start counting from zero
    always_comb begin
        case (state_q)
            BOOT_RESET,
            BOOT_TX_DONE,
            BOOT_RX_DONE: cnt_clear = 1'b1;
            default:      cnt_clear = 1'b0;
        endcase
    end

    //////////////////////////////
    // Next state
    //////////////////////////////

    always_comb begin
        // Hold by default
        state_next = state_q;
        case (state_q)
            BOOT_RESET: begin
                state_next = BOOT_EN_TX;
            end
            BOOT_EN_TX: begin
                // Give the transmitters time after release
                if (cnt_q >= tick_cnt_t'(`PRBS_RESET_WAIT)) begin
                    state_next = BOOT_TX_DONE;
                end
            end
            BOOT_TX_DONE: begin
                if (tx_all_done) begin
                    state_next = BOOT_EN_RX;
                end
            end
            BOOT_EN_RX: begin
                if (cnt_q >= tick_cnt_t'(`PRBS_RESET_WAIT)) begin
                    state_next = BOOT_RX_DONE;
                end
            end
            BOOT_RX_DONE: begin
                if (rx_all_done) begin
                    state_next = BOOT_INJECT;
                end
            end
            BOOT_INJECT: begin
                // End of the forced error window
                if (cnt_q == tick_cnt_t'(`PRBS_INJECT_TICKS)) begin
                    state_next = BOOT_INJECT_CLEAR;
                end
            end
            BOOT_INJECT_CLEAR: begin
                state_next = BOOT_CHECK;
            end
            BOOT_CHECK: begin
                state_next = BOOT_CHECK;
            end
            default: begin
                state_next = BOOT_RESET;
            end
        endcase
    end

    //////////////////////////////
    // Transceiver controls
    //////////////////////////////

    always_comb begin
        // Everything held, no injection
        full_tx_reset_o     = '1;
        full_rx_reset_o     = '1;
        prbs_count_reset_o  = 1'b1;
        prbs_error_inject_o = 1'b0;
        case (state_q)
            BOOT_EN_TX,
            BOOT_TX_DONE: begin
                full_tx_reset_o = '0;
            end
            BOOT_EN_RX: begin
                full_tx_reset_o = '0;
                full_rx_reset_o = '0;
            end
            BOOT_RX_DONE,
            BOOT_INJECT: begin
                // Error counters run while errors are forced
                full_tx_reset_o     = '0;
                full_rx_reset_o     = '0;
                prbs_count_reset_o  = 1'b0;
                prbs_error_inject_o = 1'b1;
            end
            BOOT_INJECT_CLEAR: begin
                // Counters cleared, links stay up
                full_tx_reset_o = '0;
                full_rx_reset_o = '0;
            end
            BOOT_CHECK: begin
                full_tx_reset_o     = '0;
                full_rx_reset_o     = '0;
                prbs_count_reset_o  = 1'b0;
                // Button driven error injection
                prbs_error_inject_o = inject_i;
            end
            default: begin
                full_tx_reset_o = '1;
            end
        endcase
    end

    assign boot_state_o = state_q;

    // Receivers come up only behind the transmitters
    a_rx_after_tx: assert property (@(posedge clk40) disable iff (PRBS_reset)
        (|full_tx_reset_o) |-> (&full_rx_reset_o));

    // No forced errors into counters held in reset
    a_inject_counting: assert property (@(posedge clk40) disable iff (PRBS_reset)
        prbs_error_inject_o |-> !prbs_count_reset_o);

endmodule

// ==== verilog/slow_tick_gen.sv ====
`timescale 1ns/1ps
`include "prbs_test_macros.svh"

module slow_tick_gen (
    input  logic clk40,
    input  logic PRBS_reset,
    output logic slow_tick_o,
    output logic blink_o
);

    // Free running divider count
    logic [`PRBS_DIV_W-1:0] div_cnt_q;
    // Registered terminal count
    logic                   tick_q;
    logic                   blink_q;
    logic                   div_wrap;

    // Last count of the divider period
    assign div_wrap = (div_cnt_q == `PRBS_DIV_W'(`PRBS_SLOW_DIV - 1));

    //////////////////////////////
    // Divider
    //////////////////////////////

    always_ff @(posedge clk40) begin
        if (PRBS_reset) begin
            div_cnt_q <= '0;
            tick_q    <= 1'b0;
        end else begin
            // Wrap back to zero at the end of the period
            if (div_wrap) begin
                div_cnt_q <= '0;
            end else begin
                div_cnt_q <= div_cnt_q + 1'b1;
            end
            // One cycle pulse a full period after reset drops
            tick_q <= div_wrap;
        end
    end

    // Front panel blink phase flips once per tick
    always_ff @(posedge clk40) begin
        if (PRBS_reset) begin
            blink_q <= 1'b0;
        end else if (tick_q) begin
            blink_q <= ~blink_q;
        end
    end

    assign slow_tick_o = tick_q;
    assign blink_o     = blink_q;

    // Tick is a single cycle enable
    a_tick_single: assert property (@(posedge clk40) disable iff (PRBS_reset)
        tick_q |=> !tick_q);

endmodule

// ==== verilog/prbs_test_pkg.sv ====
`include "prbs_test_macros.svh"

package prbs_test_pkg;

    // One bit per transceiver lane
    typedef logic [`PRBS_NUM_LANES-1:0] lane_vec_t;

    // One bit per front panel lane
    typedef logic [`PRBS_DISP_LANES-1:0] disp_vec_t;

    // Slow tick counter of the boot sequence
    typedef logic [`PRBS_CNT_W-1:0] tick_cnt_t;

    // LED upper nibble
    typedef logic [`PRBS_LED_CODE_W-1:0] led_code_t;

    // Link bring-up steps, in the order they are taken
    typedef enum logic [`PRBS_STATE_W-1:0] {
        BOOT_RESET,
        BOOT_EN_TX,
        BOOT_TX_DONE,
        BOOT_EN_RX,
        BOOT_RX_DONE,
        BOOT_INJECT,
        BOOT_INJECT_CLEAR,
        BOOT_CHECK
    } boot_state_t;

endpackage

// ==== verilog/prbs_test_macros.svh ====
`ifndef PRBS_TEST_MACROS_SVH
`define PRBS_TEST_MACROS_SVH

//////////////////////////////
// Lane counts
//////////////////////////////

// Transceiver lanes on the board
`define PRBS_NUM_LANES    8
// First lane shown on the front panel
`define PRBS_DISP_BASE    4
// Displayed lanes run from the base up to the last lane
`define PRBS_DISP_LANES   (`PRBS_NUM_LANES - `PRBS_DISP_BASE)

//////////////////////////////
// Timing
//////////////////////////////

// clk40 cycles per slow tick kept short for simulation
`define PRBS_SLOW_DIV     16
// Divider count width that holds PRBS_SLOW_DIV - 1
`define PRBS_DIV_W        4
// Boot tick counter width
`define PRBS_CNT_W        6
// Ticks spent after a reset is released
`define PRBS_RESET_WAIT   3
// Counter value that ends forced error injection
`define PRBS_INJECT_TICKS 31
// Boot state encoding width
`define PRBS_STATE_W      3

//////////////////////////////
// Front panel
//////////////////////////////

`define PRBS_LED_W        8
`define PRBS_LED_CODE_W   4
// Upper nibble code per boot state
`define PRBS_LED_RESET    4'd1
`define PRBS_LED_TX       4'd2
`define PRBS_LED_TX_DONE  4'd3
`define PRBS_LED_RX       4'd4
`define PRBS_LED_RX_DONE  4'd5
`define PRBS_LED_INJECT   4'd6
`define PRBS_LED_CLEAR    4'd7
`define PRBS_LED_CHECK    4'd10

`endif
